// ==== compile.f ====
logic/board_pkg.sv
logic/tick_prescaler.sv
logic/host_handshake.sv
logic/axis_watchdog.sv
logic/power_settle_timer.sv
logic/board_regs.sv
logic/board_ctrl_top.sv
tb/board_ctrl_sva.sv
tb/board_ctrl_tb.sv

// ==== tb/board_ctrl_tb.sv ====
module board_ctrl_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int tick_width   = 3;
    localparam int settle_ticks = 6;
    localparam int tick_len     = 1 << tick_width;        // sysclk cycles per tick
    localparam int n_rand       = 80;
    localparam int n_enable     = 12;
    localparam int n_kick       = 10;
    localparam int xfer_budget  = 24 + n_rand + 2 * n_enable + 2 * n_kick;
    localparam int wait_budget  = 2 * (settle_ticks + 2) * tick_len + 40 * tick_len
                                  + 8 * n_kick + 32;
    // mapped, read-only, unmapped and off-board addresses
    localparam board_pkg::reg_addr_t addr_pool [10] = '{8'h01, 8'h02, 8'h06, 8'h05,
        8'h0A, 8'h03, 8'h08, 8'h0D, 8'h31, 8'hF6};

    logic sysclk = 1'b0;
    logic reset = 1'b0, req = 1'b0, we = 1'b0, relay = 1'b0, mv_good = 1'b1, v_fault = 1'b0;
    logic ack, pwr_enable, relay_on;
    board_pkg::reg_addr_t  addr = '0;
    board_pkg::reg_word_t  wdata = '0, rdata;
    board_pkg::axis_mask_t neg_limit = '0, pos_limit = '0, home = '0, fault = '0;
    board_pkg::axis_mask_t safety_amp_disable = '0, amp_disable, dout;
    logic [3:0]  board_id = 4'hA;
    logic [15:0] temp_sense = '0;

    // reference model of the register file
    board_pkg::axis_mask_t m_dis = '1, m_dout = '0;
    logic        m_pwr = 1'b0, m_relay = 1'b0, m_timeout = 1'b0;
    logic [15:0] m_phyctrl = '0, m_phydata = '0, m_period = '0;
    integer      seed = 5168;

    board_ctrl_top #(.tick_width(tick_width), .settle_ticks(settle_ticks))
        board_ctrl_top_i (.*);

    always #50 sysclk = ~sysclk;    // 100 ns period

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    task automatic abort_run(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input board_pkg::reg_word_t exp,
                              input board_pkg::reg_word_t act);
        if (act !== exp) abort_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_mask(input string name, input board_pkg::axis_mask_t exp,
                              input board_pkg::axis_mask_t act);
        if (act !== exp) abort_run($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) abort_run($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
    endtask

    task automatic check_pins(input string name);
        check_mask({name, " amp_disable"}, m_dis, amp_disable);     // supply settled here
        check_mask({name, " dout"}, m_dout, dout);
        check_bit({name, " pwr_enable"}, m_pwr, pwr_enable);
        check_bit({name, " relay_on"}, m_relay, relay_on);
    endtask

    // ------------------------------------------------------------------------
    // model
    // ------------------------------------------------------------------------
    task automatic model_write(input board_pkg::reg_addr_t a, input board_pkg::reg_word_t d);
        logic pwr_new;
        pwr_new = d[19] ? d[18] : m_pwr;
        if (a[7:4] != 4'd0) return;                                 // not a board reg
        case (a[3:0])
            4'd0: begin
                for (int i = 0; i < 4; i++) begin
                    m_dis[i] = (!m_pwr || !pwr_new) ? 1'b1 : (d[8+i] ? !d[i] : m_dis[i]);
                end
                if (d[17]) m_relay = d[16];
                m_pwr = pwr_new;
            end
            4'd1: m_phyctrl = d[15:0];
            4'd2: m_phydata = d[15:0];
            4'd3: m_period = d[15:0];
            4'd6: for (int i = 0; i < 4; i++) if (d[8+i]) m_dout[i] = d[i];
            default: ;
        endcase
    endtask

    function automatic board_pkg::reg_word_t expect_read(input board_pkg::reg_addr_t a);
        if (a[7:4] != 4'd0) return '0;
        case (a[3:0])
            4'd0: return {board_pkg::num_axes, board_id, m_timeout, 3'd0, mv_good, m_pwr,
                          ~relay, m_relay, 4'd0, fault, safety_amp_disable, ~m_dis};
            4'd1: return {16'd0, m_phyctrl};
            4'd2: return {16'd0, m_phydata};
            4'd3: return {16'd0, m_period};
            4'd4: return board_pkg::board_version;
            4'd5: return {16'd0, temp_sense};
            4'd6: return {28'd0, m_dout};
            4'd7: return board_pkg::fw_version;
            4'd10: return {15'd0, v_fault, m_dout, neg_limit, pos_limit, home};
            4'd11: return {28'd0, safety_amp_disable};
            4'd14: return {28'd0, {4{m_timeout}}};                  // watchdog trips all
            4'd15: return {28'd0, m_dis};
            default: return '0;
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // host bus
    // ------------------------------------------------------------------------
    task automatic bus_access(input string name, input logic w, input board_pkg::reg_addr_t a,
                              input board_pkg::reg_word_t d);
        board_pkg::reg_word_t rd;
        repeat ($random(seed) & 3) @(posedge sysclk);              // idle gap
        req   <= 1'b1;
        we    <= w;
        addr  <= a;
        wdata <= d;
        do @(posedge sysclk); while (!ack);
        rd = rdata;
        req <= 1'b0;
        do @(posedge sysclk); while (ack);                          // four-phase close
        if (w) model_write(a, d);
        else check_word(name, expect_read(a), rd);
    endtask

    initial begin
        repeat (xfer_budget * 12 + wait_budget) @(posedge sysclk);
        abort_run("run did not finish, bus handshake or timer hung");
    end

    initial begin
        wait (board_ctrl_top_i.sva_i.failures != 0);
        abort_run("a bound assertion failed");
    end

    initial begin
        board_pkg::reg_word_t d;
        int cycles;
        repeat (3) @(posedge sysclk);
        reset <= 1'b1;
        @(posedge sysclk);
        bus_access("reset status", 1'b0, 8'h00, '0);
        bus_access("version", 1'b0, 8'h04, '0);
        bus_access("fw version", 1'b0, 8'h07, '0);
        check_pins("reset");
        neg_limit  <= $random(seed);                                // held from here on
        pos_limit  <= $random(seed);
        home       <= $random(seed);
        fault      <= $random(seed);
        temp_sense <= $random(seed);
        v_fault    <= $random(seed);
        relay      <= $random(seed);
        repeat ((settle_ticks + 2) * tick_len) @(posedge sysclk);  // let mv_good settle

        // --------------------------------------------------------------------
        // random register traffic with power off
        // --------------------------------------------------------------------
        for (int n = 0; n < n_rand; n++) begin
            board_pkg::reg_addr_t a;
            a = addr_pool[$unsigned($random(seed)) % 10];
            d = $random(seed);
            if (a == 8'h03) d = '0;                                 // watchdog stays off
            bus_access("random access", $random(seed) & 1, a, d);
            check_pins("random access");
        end

        // amp enables while off, then powered
        d = $random(seed);
        d[19] = 1'b0;
        bus_access("enable while off", 1'b1, 8'h00, d);
        check_pins("enable while off");
        bus_access("power on", 1'b1, 8'h00, 32'h000F_0000);
        for (int n = 0; n < n_enable; n++) begin
            d = $random(seed);
            d[19:18] = 2'b11;                                       // keep power on
            bus_access("enable write", 1'b1, 8'h00, d);
            check_pins("enable write");
            bus_access("enable status", 1'b0, 8'h00, '0);
        end

        // --------------------------------------------------------------------
        // safety latch
        // --------------------------------------------------------------------
        d = $random(seed);
        safety_amp_disable <= (d[3:0] == 4'd0) ? 4'b1000 : d[3:0];
        repeat (3) @(posedge sysclk);
        m_dis = m_dis | safety_amp_disable;
        check_pins("safety trip");
        bus_access("safety status", 1'b0, 8'h00, '0);
        bus_access("safety readback", 1'b0, 8'h0B, '0);
        bus_access("safety regdisable", 1'b0, 8'h0F, '0);
        safety_amp_disable <= '0;
        repeat (3) @(posedge sysclk);
        check_pins("safety released");                              // still latched
        bus_access("safety re-enable", 1'b1, 8'h00, 32'h000C_0F0F);
        check_pins("safety re-enable");

        // watchdog with a 4 tick period
        bus_access("set period", 1'b1, 8'h03, 32'd4);
        for (int n = 0; n < n_kick; n++) begin
            repeat (8) @(posedge sysclk);
            bus_access("kick", 1'b1, 8'h02, $random(seed));
            bus_access("kick status", 1'b0, 8'h00, '0);
        end
        repeat (8 * tick_len * 5) @(posedge sysclk);               // host silent
        m_timeout = 1'b1;
        m_dis     = '1;
        bus_access("timeout status", 1'b0, 8'h00, '0);
        bus_access("timeout wdog", 1'b0, 8'h0E, '0);
        check_pins("timeout");
        bus_access("clear period", 1'b1, 8'h03, '0);
        m_timeout = 1'b0;                                           // the write kicked
        bus_access("recover", 1'b1, 8'h00, 32'h000C_0F0F);
        check_pins("recover");

        // --------------------------------------------------------------------
        // motor supply drop and settle
        // --------------------------------------------------------------------
        mv_good <= 1'b0;
        cycles = 0;
        while (amp_disable !== 4'hF) begin
            @(posedge sysclk);
            cycles++;
            if (cycles > tick_len + 2) abort_run("amp_disable not set after mv_good fell");
        end
        bus_access("supply low status", 1'b0, 8'h00, '0);
        mv_good <= 1'b1;
        cycles = 0;
        while (amp_disable === 4'hF) begin
            @(posedge sysclk);
            cycles++;
            if (cycles > (settle_ticks + 2) * tick_len)
                abort_run("amp_disable stuck after mv_good rose");
        end
        if (cycles < (settle_ticks - 1) * tick_len)
            abort_run("amp_disable released before the supply settled");
        check_pins("settled");

        if (board_ctrl_top_i.sva_i.failures == 0) begin
            $display("test passed");
            $finish;
        end else begin
            abort_run("a bound assertion failed");
        end
    end

endmodule

// ==== tb/board_ctrl_sva.sv ====
module board_ctrl_sva (
    input logic                  sysclk,
    input logic                  reset,
    input logic                  req,
    input logic                  ack,
    input logic                  acc_strobe,
    input logic                  pwr_enable,
    input board_pkg::axis_mask_t amp_disable
);
    timeunit 1ns;
    timeprecision 1ps;

    int failures = 0;   // tally of assertion failures

    // ------------------------------------------------------------------------
    // four-phase handshake
    // ------------------------------------------------------------------------
    ack_needs_req: assert property (@(posedge sysclk) disable iff (!reset)
        $rose(ack) |-> req)
        else begin
            $error("ack rose without req");
            failures++;
        end

    strobe_single: assert property (@(posedge sysclk) disable iff (!reset)
        acc_strobe |=> !acc_strobe)                                 // one per transfer
        else begin
            $error("acc_strobe wider than one cycle");
            failures++;
        end

    ack_release: assert property (@(posedge sysclk) disable iff (!reset)
        $fell(req) |-> ##[0:2] !ack)
        else begin
            $error("ack held after req fell");
            failures++;
        end

    // power off means every axis off
    amp_off_unpowered: assert property (@(posedge sysclk) disable iff (!reset)
        !pwr_enable |-> amp_disable == 4'hF)
        else begin
            $error("axis enabled while power is off");
            failures++;
        end

endmodule

bind board_ctrl_top board_ctrl_sva sva_i (
    .sysclk, .reset, .req, .ack, .acc_strobe, .pwr_enable, .amp_disable
);

// ==== logic/board_ctrl_top.sv ====
module board_ctrl_top #(
    parameter int tick_width   = 8,         // timer tick is 2^tick_width cycles
    parameter int settle_ticks = 7680       // mv_good hold-off in ticks
) (
    input  logic                   sysclk,
    input  logic                   reset,
    // host bus
    input  logic                   req,
    input  logic                   we,
    input  board_pkg::reg_addr_t   addr,
    input  board_pkg::reg_word_t   wdata,
    output logic                   ack,
    output board_pkg::reg_word_t   rdata,
    // board pins
    output board_pkg::axis_mask_t  amp_disable,
    output board_pkg::axis_mask_t  dout,
    output logic                   pwr_enable,
    output logic                   relay_on,
    input  board_pkg::axis_mask_t  neg_limit,
    input  board_pkg::axis_mask_t  pos_limit,
    input  board_pkg::axis_mask_t  home,
    input  board_pkg::axis_mask_t  fault,
    input  board_pkg::axis_mask_t  safety_amp_disable,
    input  logic                   relay,
    input  logic                   mv_good,
    input  logic                   v_fault,
    input  logic [3:0]             board_id,
    input  logic [15:0]            temp_sense
);

    logic                  acc_strobe, acc_we;
    board_pkg::reg_addr_t  acc_addr;
    board_pkg::reg_word_t  acc_wdata, acc_rdata;
    logic                  tick;
    logic [15:0]           wdog_period;
    logic                  wdog_timeout;
    board_pkg::axis_mask_t wdog_disable, settle_disable;

    // ------------------------------------------------------------------------
    // bus slave and register file
    // ------------------------------------------------------------------------
    host_handshake host_handshake_i (
        .sysclk, .reset, .req, .we, .addr, .wdata, .ack, .rdata,
        .acc_strobe, .acc_we, .acc_addr, .acc_wdata, .acc_rdata
    );

    board_regs board_regs_i (
        .sysclk, .reset, .acc_strobe, .acc_we, .acc_addr, .acc_wdata, .acc_rdata,
        .amp_disable, .dout, .pwr_enable, .relay_on,
        .neg_limit, .pos_limit, .home, .fault, .safety_amp_disable,
        .relay, .mv_good, .v_fault, .board_id, .temp_sense,
        .wdog_period, .wdog_timeout, .wdog_disable, .settle_disable
    );

    // ------------------------------------------------------------------------
    // timers on the shared tick
    // ------------------------------------------------------------------------
    tick_prescaler #(.tick_width(tick_width)) tick_prescaler_i (
        .sysclk, .reset, .tick
    );

    axis_watchdog axis_watchdog_i (
        .sysclk, .reset, .tick,
        .kick (acc_strobe & acc_we),        // every host write feeds the dog
        .wdog_period, .wdog_timeout, .wdog_disable
    );

    power_settle_timer #(.settle_ticks(settle_ticks)) power_settle_timer_i (
        .sysclk, .reset, .tick, .mv_good, .settle_disable
    );

endmodule

// ==== logic/board_regs.sv ====
module board_regs (
    input  logic                   sysclk,
    input  logic                   reset,
    // register access from the bus slave
    input  logic                   acc_strobe,
    input  logic                   acc_we,
    input  board_pkg::reg_addr_t   acc_addr,
    input  board_pkg::reg_word_t   acc_wdata,
    output board_pkg::reg_word_t   acc_rdata,
    // board controls
    output board_pkg::axis_mask_t  amp_disable,
    output board_pkg::axis_mask_t  dout,
    output logic                   pwr_enable,
    output logic                   relay_on,
    // board readback
    input  board_pkg::axis_mask_t  neg_limit,
    input  board_pkg::axis_mask_t  pos_limit,
    input  board_pkg::axis_mask_t  home,
    input  board_pkg::axis_mask_t  fault,
    input  board_pkg::axis_mask_t  safety_amp_disable,
    input  logic                   relay,
    input  logic                   mv_good,
    input  logic                   v_fault,
    input  logic [3:0]             board_id,        // rotary switch
    input  logic [15:0]            temp_sense,
    // timers
    output logic [15:0]            wdog_period,
    input  logic                   wdog_timeout,
    input  board_pkg::axis_mask_t  wdog_disable,
    input  board_pkg::axis_mask_t  settle_disable
);

    board_pkg::axis_mask_t reg_disable;     // host controlled, latched
    logic [15:0]           phy_ctrl;
    logic [15:0]           phy_data;
    logic                  board_sel;       // upper nibble clear
    logic                  wr_en;
    logic                  pwr_next;        // pwr_enable after this write

    assign board_sel = (acc_addr[7:4] == 4'd0);
    assign wr_en     = acc_strobe && acc_we && board_sel;
    assign pwr_next  = acc_wdata[19] ? acc_wdata[18] : pwr_enable;

    // settle hold-off never latches, just overrides
    assign amp_disable = reg_disable | settle_disable;

    // ------------------------------------------------------------------------
    // control writes
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            reg_disable <= '1;              // everything off at start
            pwr_enable  <= 1'b0;
            relay_on    <= 1'b0;
            dout        <= '0;
            phy_ctrl    <= '0;
            phy_data    <= '0;
            wdog_period <= '0;              // watchdog off
        end else if (wr_en) begin
            case (acc_addr[3:0])
                board_pkg::reg_status: begin
                    // enable bits 3:0 masked by 11:8, disable = ~enable
                    // forced off while power is off before or after the write
                    for (int i = 0; i < 4; i++) begin
                        reg_disable[i] <= ~pwr_enable | ~pwr_next |
                            (acc_wdata[8+i] ? ~acc_wdata[i] : reg_disable[i]);
                    end
                    if (acc_wdata[17]) relay_on <= acc_wdata[16];   // relay mask
                    pwr_enable <= pwr_next;
                end
                board_pkg::reg_phyctrl: phy_ctrl    <= acc_wdata[15:0];
                board_pkg::reg_phydata: phy_data    <= acc_wdata[15:0];
                board_pkg::reg_timeout: wdog_period <= acc_wdata[15:0];
                board_pkg::reg_digiout: begin
                    for (int i = 0; i < 4; i++) begin
                        if (acc_wdata[8+i]) dout[i] <= acc_wdata[i];   // masked
                    end
                end
                default: ;                  // read-only or unmapped
            endcase
        end else begin
            // latch watchdog and safety trips until the host re-enables
            reg_disable <= reg_disable | wdog_disable | safety_amp_disable;
        end
    end

    // ------------------------------------------------------------------------
    // read mux, captured on the strobe edge
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (acc_strobe && !acc_we) begin
            if (!board_sel) begin
                acc_rdata <= '0;            // not a board register
            end else begin
                case (acc_addr[3:0])
                    board_pkg::reg_status: acc_rdata <= {
                        board_pkg::num_axes, board_id,
                        wdog_timeout, 3'd0, mv_good, pwr_enable, ~relay, relay_on,
                        4'd0, fault,
                        safety_amp_disable, ~reg_disable};  // 1 means enabled
                    board_pkg::reg_phyctrl:    acc_rdata <= {16'd0, phy_ctrl};
                    board_pkg::reg_phydata:    acc_rdata <= {16'd0, phy_data};
                    board_pkg::reg_timeout:    acc_rdata <= {16'd0, wdog_period};
                    board_pkg::reg_version:    acc_rdata <= board_pkg::board_version;
                    board_pkg::reg_tempsns:    acc_rdata <= {16'd0, temp_sense};
                    board_pkg::reg_digiout:    acc_rdata <= {28'd0, dout};
                    board_pkg::reg_fw_version: acc_rdata <= board_pkg::fw_version;
                    board_pkg::reg_digin: acc_rdata <= {
                        15'd0, v_fault, dout, neg_limit, pos_limit, home};
                    board_pkg::reg_safety:     acc_rdata <= {28'd0, safety_amp_disable};
                    board_pkg::reg_wdog:       acc_rdata <= {28'd0, wdog_disable};
                    board_pkg::reg_regdisable: acc_rdata <= {28'd0, amp_disable};
                    default:                   acc_rdata <= '0;
                endcase
            end
        end
    end

endmodule

// ==== logic/power_settle_timer.sv ====
module power_settle_timer #(
    parameter int settle_ticks = 7680       // about 40 ms at the default tick
) (
    input  logic                   sysclk,
    input  logic                   reset,
    input  logic                   tick,
    input  logic                   mv_good,         // motor supply in range
    output board_pkg::axis_mask_t  settle_disable
);

    localparam int cnt_w = $clog2(settle_ticks + 1);
    localparam logic [cnt_w-1:0] settle_last = cnt_w'(settle_ticks);

    logic [cnt_w-1:0] count;    // ticks of steady mv_good

    // ------------------------------------------------------------------------
    // motor voltage settle hold-off
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            count          <= '0;
            settle_disable <= '1;           // axes off until supply settles
        end else if (tick) begin
            if (!mv_good) begin
                count          <= '0;       // supply dropped, restart
                settle_disable <= '1;
            end else if (count < settle_last) begin
                count          <= count + 1'b1;
                settle_disable <= '1;
            end else begin
                settle_disable <= '0;       // settled, release
            end
        end
    end

endmodule

// ==== logic/axis_watchdog.sv ====
module axis_watchdog (
    input  logic                   sysclk,
    input  logic                   reset,
    input  logic                   tick,            // prescaler enable
    input  logic                   kick,            // any host write
    input  logic [15:0]            wdog_period,     // in ticks, 0 is off
    output logic                   wdog_timeout,
    output board_pkg::axis_mask_t  wdog_disable
);

    logic [15:0] count;     // ticks since last kick

    // ------------------------------------------------------------------------
    // host write watchdog
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            count        <= '0;
            wdog_timeout <= 1'b0;
            wdog_disable <= '0;
        end else if (kick) begin
            count        <= '0;             // host alive, start over
            wdog_timeout <= 1'b0;
            wdog_disable <= '0;
        end else if (tick && wdog_period != 16'd0) begin
            if (count < wdog_period) begin
                count <= count + 1'b1;
            end else begin
                // saturated, host gone quiet
                wdog_timeout <= 1'b1;
                wdog_disable <= '1;         // drop every axis
            end
        end
    end

endmodule

// ==== logic/host_handshake.sv ====
module host_handshake (
    input  logic                  sysclk,
    input  logic                  reset,
    // four-phase host side
    input  logic                  req,
    input  logic                  we,
    input  board_pkg::reg_addr_t  addr,
    input  board_pkg::reg_word_t  wdata,
    output logic                  ack,
    output board_pkg::reg_word_t  rdata,
    // register access side
    output logic                  acc_strobe,
    output logic                  acc_we,
    output board_pkg::reg_addr_t  acc_addr,
    output board_pkg::reg_word_t  acc_wdata,
    input  board_pkg::reg_word_t  acc_rdata
);

    typedef enum logic [1:0] {
        st_idle,        // waiting for req
        st_access,      // strobe cycle
        st_capture,     // read data lands from the register file
        st_ack          // ack high until req drops
    } hs_state_t;

    hs_state_t state;

    // ------------------------------------------------------------------------
    // transfer sequencer
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:    if (req) state <= st_access;   // new transfer
                st_access:  state <= st_capture;
                st_capture: state <= st_ack;
                st_ack:     if (!req) state <= st_idle;    // host done
                default:    state <= st_idle;
            endcase
        end
    end

    // host inputs are stable until ack, grab them once at the start
    always_ff @(posedge sysclk) begin
        if (state == st_idle && req) begin
            acc_we    <= we;
            acc_addr  <= addr;
            acc_wdata <= wdata;
        end
        if (state == st_capture) begin
            rdata <= acc_rdata;             // held for the whole ack phase
        end
    end

    assign acc_strobe = (state == st_access);   // exactly one per transfer
    assign ack        = (state == st_ack);

endmodule

// ==== logic/tick_prescaler.sv ====
module tick_prescaler #(
    parameter int tick_width = 8            // tick every 2^tick_width cycles
) (
    input  logic sysclk,
    input  logic reset,                     // sync, active low
    output logic tick
);

    // ------------------------------------------------------------------------
    // free-running divider
    // ------------------------------------------------------------------------
    logic [tick_width-1:0] count;

    always_ff @(posedge sysclk) begin
        if (!reset) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;          // wraps on its own
        end
    end

    // one cycle wide, on the last count before the wrap
    assign tick = &count;

endmodule

// ==== logic/board_pkg.sv ====
package board_pkg;

    // ------------------------------------------------------------------------
    // shared word types
    // ------------------------------------------------------------------------
    typedef logic [31:0] reg_word_t;    // host register data
    typedef logic [7:0]  reg_addr_t;    // upper nibble zero for board regs
    typedef logic [3:0]  axis_mask_t;   // bit 0 is axis 1

    // ------------------------------------------------------------------------
    // board register map by low address nibble
    // ------------------------------------------------------------------------
    localparam logic [3:0] reg_status     = 4'd0;    // ids, faults, enables
    localparam logic [3:0] reg_phyctrl    = 4'd1;    // phy request word
    localparam logic [3:0] reg_phydata    = 4'd2;    // phy data holder
    localparam logic [3:0] reg_timeout    = 4'd3;    // watchdog period
    localparam logic [3:0] reg_version    = 4'd4;    // hard-wired board id word
    localparam logic [3:0] reg_tempsns    = 4'd5;    // temperature readback
    localparam logic [3:0] reg_digiout    = 4'd6;    // masked digital outputs
    localparam logic [3:0] reg_fw_version = 4'd7;    // firmware revision
    localparam logic [3:0] reg_digin      = 4'd10;   // limits, home, v_fault
    localparam logic [3:0] reg_safety     = 4'd11;   // external safety disables
    localparam logic [3:0] reg_wdog       = 4'd14;   // watchdog axis disables
    localparam logic [3:0] reg_regdisable = 4'd15;   // combined amp disables

    // 8, 9, 12 and 13 belong to the external flash controller

    // ------------------------------------------------------------------------
    // constants
    // ------------------------------------------------------------------------
    localparam reg_word_t board_version = 32'h514C4131;   // "QLA1" in ascii
    localparam reg_word_t fw_version    = 32'd4;
    localparam logic [3:0] num_axes     = 4'd4;            // top nibble of status

endpackage
